// File: source/isaPkg.sv
// Instruction codes are internal decode-stage codes, not MIPS opcode bits; NOP must stay zero
package isaPkg;

    // Decoded instruction codes
    typedef enum logic [5:0] {
        NOP = 6'd0,
        ADD, ADDU, SUB, SUBU, AND, OR, XOR, NOR,
        SLT, SLTU, SLL, SRL, SRA, SLLV, SRLV, SRAV,
        ADDI, ADDIU, ANDI, ORI, XORI, LUI, SLTI, SLTIU,
        LW, SW,
        MULT, MULTU, DIV, DIVU,
        MFHI, MFLO, MTHI, MTLO
    } instrE;

    typedef enum logic {
        FORMAT_R,
        FORMAT_I
    } formatE;

    typedef enum logic [2:0] {
        CALC_R, CALC_I, MEM_READ, MEM_WRITE, MULT_DIV, MOVE_HILO, NONE
    } funcE;

    typedef enum logic [3:0] {
        ALU_ZERO, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } aluOpE;

    // Busy time after a multiply or divide starts
    localparam int MULT_CYCLES = 5;
    localparam int DIV_CYCLES = 10;

    // Countdown wide enough for the longest latency
    localparam int MD_COUNT_W = $clog2(DIV_CYCLES + 1);
    typedef logic [MD_COUNT_W-1:0] mdCountT;

endpackage

// File: source/pipePkg.sv
// Pipeline records between decode, execute and memory; field order is fixed by the packed layout
package pipePkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0] regAddrT;
    typedef logic [15:0] imm16T;
    typedef logic [4:0] shamtT;
    typedef logic [1:0] tNewT;

    // From the decode stage
    typedef struct packed {
        isaPkg::instrE instr;
        wordT pc;
        wordT dataRs;
        wordT dataRt;
        imm16T imm16;
        shamtT shamt;
        regAddrT addrRs;
        regAddrT addrRt;
        regAddrT regWriteAddr;
        wordT regWriteData;
        tNewT tNew;
    } exInputT;

    // One bypass source, addr 0 means no write
    typedef struct packed {
        regAddrT addr;
        wordT data;
    } bypassT;

    // To the memory stage
    typedef struct packed {
        isaPkg::instrE instr;
        wordT pc;
        wordT aluOut;
        wordT memWriteData;
        regAddrT addrRt;
        regAddrT regWriteAddr;
        wordT regWriteData;
        tNewT tNew;
    } memInputT;

endpackage

// File: source/instrClassifier.sv
// Purely combinational; codes outside the table classify as an R-format instruction with no function
module instrClassifier (
    input  isaPkg::instrE  instr,
    output isaPkg::formatE format,
    output isaPkg::funcE   func
);
    import isaPkg::*;

    always_comb begin
        format = FORMAT_R;
        func = NONE;
        case (instr)
            ADD, ADDU, SUB, SUBU, AND, OR, XOR, NOR,
            SLT, SLTU, SLL, SRL, SRA, SLLV, SRLV, SRAV: begin
                func = CALC_R;
            end
            ADDI, ADDIU, ANDI, ORI, XORI, LUI, SLTI, SLTIU: begin
                format = FORMAT_I;
                func = CALC_I;
            end
            // Loads and stores use the immediate as offset
            LW: begin
                format = FORMAT_I;
                func = MEM_READ;
            end
            SW: begin
                format = FORMAT_I;
                func = MEM_WRITE;
            end
            MULT, MULTU, DIV, DIVU: begin
                func = MULT_DIV;
            end
            MFHI, MFLO, MTHI, MTLO: begin
                func = MOVE_HILO;
            end
            default: begin
                func = NONE;
            end
        endcase
    end

endmodule

// File: source/operandForward.sv
// Bypass sources carry the value to be written back; an address of 0 never forwards
module operandForward (
    input  pipePkg::regAddrT addrRs,
    input  pipePkg::regAddrT addrRt,
    input  pipePkg::wordT    dataRs,
    input  pipePkg::wordT    dataRt,
    input  pipePkg::bypassT  bypassMem,
    input  pipePkg::bypassT  bypassWb,
    output pipePkg::wordT    rsValue,
    output pipePkg::wordT    rtValue
);
    import pipePkg::*;

    // Memory stage is younger, so it wins
    function automatic wordT pickOperand(regAddrT addr, wordT regFileData);
        if (addr != '0 && bypassMem.addr == addr) begin
            return bypassMem.data;
        end else if (addr != '0 && bypassWb.addr == addr) begin
            return bypassWb.data;
        end
        return regFileData;
    endfunction

    always_comb begin
        rsValue = pickOperand(addrRs, dataRs);
        rtValue = pickOperand(addrRt, dataRt);
    end

endmodule

// File: source/aluUnit.sv
// No overflow trap; ADD and ADDU compute the same wrapped sum, as do SUB and SUBU
module aluUnit (
    input  isaPkg::instrE  instr,
    input  isaPkg::formatE format,
    input  isaPkg::funcE   func,
    input  pipePkg::wordT  rsValue,
    input  pipePkg::wordT  rtValue,
    input  pipePkg::imm16T imm16,
    input  pipePkg::shamtT shamt,
    output pipePkg::wordT  aluOut
);
    import isaPkg::*;
    import pipePkg::*;

    logic zeroExt;
    wordT extImm;
    wordT srcA;
    wordT srcB;
    aluOpE aluOp;

    // Logical immediates and LUI zero-extend
    assign zeroExt = (instr == ANDI) || (instr == ORI) || (instr == XORI) || (instr == LUI);
    assign extImm = zeroExt ? {16'b0, imm16} : {{16{imm16[15]}}, imm16};

    // Constant shifts take the amount from shamt
    assign srcA = (instr == SLL || instr == SRL || instr == SRA) ? {27'b0, shamt} : rsValue;
    assign srcB = (format == FORMAT_I) ? extImm : rtValue;

    always_comb begin
        if (func == MEM_READ || func == MEM_WRITE) begin
            aluOp = ALU_ADD;
        end else begin
            case (instr)
                ADD, ADDU, ADDI, ADDIU: aluOp = ALU_ADD;
                SUB, SUBU: aluOp = ALU_SUB;
                AND, ANDI: aluOp = ALU_AND;
                OR, ORI: aluOp = ALU_OR;
                XOR, XORI: aluOp = ALU_XOR;
                NOR: aluOp = ALU_NOR;
                SLT, SLTI: aluOp = ALU_SLT;
                SLTU, SLTIU: aluOp = ALU_SLTU;
                SLL, SLLV: aluOp = ALU_SLL;
                SRL, SRLV: aluOp = ALU_SRL;
                SRA, SRAV: aluOp = ALU_SRA;
                LUI: aluOp = ALU_LUI;
                default: aluOp = ALU_ZERO;
            endcase
        end
    end

    always_comb begin
        case (aluOp)
            ALU_ADD: aluOut = srcA + srcB;
            ALU_SUB: aluOut = srcA - srcB;
            ALU_AND: aluOut = srcA & srcB;
            ALU_OR: aluOut = srcA | srcB;
            ALU_XOR: aluOut = srcA ^ srcB;
            ALU_NOR: aluOut = ~(srcA | srcB);
            ALU_SLT: aluOut = {31'b0, ($signed(srcA) < $signed(srcB))};
            ALU_SLTU: aluOut = {31'b0, (srcA < srcB)};
            // Shift B by the low five bits of A
            ALU_SLL: aluOut = srcB << srcA[4:0];
            ALU_SRL: aluOut = srcB >> srcA[4:0];
            ALU_SRA: aluOut = $signed(srcB) >>> srcA[4:0];
            ALU_LUI: aluOut = {srcB[15:0], 16'b0};
            default: aluOut = '0;
        endcase
    end

endmodule

// File: source/multDivUnit.sv
// Result lands in HI/LO at the start edge; busy only models latency and a start while busy is dropped
module multDivUnit (
    input  logic          clk,
    input  logic          reset,
    input  logic          stall,
    input  isaPkg::instrE instr,
    input  pipePkg::wordT rsValue,
    input  pipePkg::wordT rtValue,
    output logic          busy,
    output pipePkg::wordT hiLoOut
);
    import isaPkg::*;
    import pipePkg::*;

    wordT hi;
    wordT lo;
    mdCountT count;
    logic isMult;
    logic isDiv;
    logic signedOp;
    logic start;
    logic [63:0] rsExt;
    logic [63:0] rtExt;
    logic [63:0] product;
    wordT quotient;
    wordT remainder;

    assign busy = (count != '0);
    assign isMult = (instr == MULT) || (instr == MULTU);
    assign isDiv = (instr == DIV) || (instr == DIVU);
    assign signedOp = (instr == MULT) || (instr == DIV);
    assign start = !stall && !busy && (isMult || isDiv);

    // Low 64 bits of the extended product match the signed result too
    assign rsExt = signedOp ? {{32{rsValue[31]}}, rsValue} : {32'b0, rsValue};
    assign rtExt = signedOp ? {{32{rtValue[31]}}, rtValue} : {32'b0, rtValue};
    assign product = rsExt * rtExt;

    always_comb begin
        if (rtValue == '0) begin
            quotient = '1;
            remainder = rsValue;
        end else if (signedOp) begin
            quotient = $signed(rsValue) / $signed(rtValue);
            remainder = $signed(rsValue) % $signed(rtValue);
        end else begin
            quotient = rsValue / rtValue;
            remainder = rsValue % rtValue;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
            count <= '0;
        end else begin
            if (busy) begin
                count <= count - 1'b1;
            end
            if (start && isDiv) begin
                count <= mdCountT'(DIV_CYCLES);
                hi <= remainder;
                lo <= quotient;
            end else if (start) begin
                count <= mdCountT'(MULT_CYCLES);
                hi <= product[63:32];
                lo <= product[31:0];
            end else if (!stall && !busy && instr == MTHI) begin
                hi <= rsValue;
            end else if (!stall && !busy && instr == MTLO) begin
                lo <= rsValue;
            end
        end
    end

    // Reads return 0 until the latency has passed
    assign hiLoOut = busy ? '0 : (instr == MFHI) ? hi : (instr == MFLO) ? lo : '0;

    assert property (@(posedge clk) disable iff (reset) count <= mdCountT'(DIV_CYCLES));

    // An operation presented while busy must not reload the countdown
    assert property (@(posedge clk) disable iff (reset)
        busy && (isMult || isDiv) |=> count == $past(count) - 1'b1);

endmodule

// File: source/exMemRegister.sv
// Clear beats stall; reset loads the same all-zero NOP bubble as clr
module exMemRegister (
    input  logic              clk,
    input  logic              reset,
    input  logic              stall,
    input  logic              clr,
    input  pipePkg::exInputT  exIn,
    input  isaPkg::funcE      func,
    input  pipePkg::wordT     aluOut,
    input  pipePkg::wordT     hiLoOut,
    input  pipePkg::wordT     rtValue,
    output pipePkg::memInputT memOut
);
    import isaPkg::*;
    import pipePkg::*;

    wordT exResult;
    memInputT memNext;

    assign exResult = (exIn.instr == MFHI || exIn.instr == MFLO) ? hiLoOut : aluOut;

    always_comb begin
        memNext.instr = exIn.instr;
        memNext.pc = exIn.pc;
        memNext.aluOut = exResult;
        memNext.memWriteData = rtValue;
        memNext.addrRt = exIn.addrRt;
        memNext.regWriteAddr = exIn.regWriteAddr;
        // Other classes keep the data handed down from decode
        case (func)
            CALC_R, CALC_I, MOVE_HILO: memNext.regWriteData = exResult;
            default: memNext.regWriteData = exIn.regWriteData;
        endcase
        memNext.tNew = (exIn.tNew != '0) ? exIn.tNew - 1'b1 : '0;
    end

    always_ff @(posedge clk) begin
        if (reset || clr) begin
            memOut <= '0;
        end else if (!stall) begin
            memOut <= memNext;
        end
    end

    assert property (@(posedge clk) clr |=> memOut.instr == NOP);

endmodule

// File: source/executeStage.sv
// Execute stage only; stall comes from an outside hazard unit, which must also hold ops while mdBusy
module executeStage (
    input  logic              clk,
    input  logic              reset,
    input  logic              stall,
    input  logic              clr,
    input  pipePkg::exInputT  exIn,
    input  pipePkg::bypassT   bypassMem,
    input  pipePkg::bypassT   bypassWb,
    output pipePkg::memInputT memOut,
    output logic              mdBusy
);
    import isaPkg::*;
    import pipePkg::*;

    formatE format;
    funcE func;
    wordT rsValue;
    wordT rtValue;
    wordT aluOut;
    wordT hiLoOut;

    instrClassifier classifier (
        .instr (exIn.instr),
        .format(format),
        .func  (func)
    );

    operandForward forward (
        .addrRs   (exIn.addrRs),
        .addrRt   (exIn.addrRt),
        .dataRs   (exIn.dataRs),
        .dataRt   (exIn.dataRt),
        .bypassMem(bypassMem),
        .bypassWb (bypassWb),
        .rsValue  (rsValue),
        .rtValue  (rtValue)
    );

    aluUnit alu (
        .instr  (exIn.instr),
        .format (format),
        .func   (func),
        .rsValue(rsValue),
        .rtValue(rtValue),
        .imm16  (exIn.imm16),
        .shamt  (exIn.shamt),
        .aluOut (aluOut)
    );

    multDivUnit multDiv (
        .clk    (clk),
        .reset  (reset),
        .stall  (stall),
        .instr  (exIn.instr),
        .rsValue(rsValue),
        .rtValue(rtValue),
        .busy   (mdBusy),
        .hiLoOut(hiLoOut)
    );

    exMemRegister exMem (
        .clk    (clk),
        .reset  (reset),
        .stall  (stall),
        .clr    (clr),
        .exIn   (exIn),
        .func   (func),
        .aluOut (aluOut),
        .hiLoOut(hiLoOut),
        .rtValue(rtValue),
        .memOut (memOut)
    );

endmodule

// File: test/executeStageTb.sv
// One table row per clock; needs a simulator with timing support, stops at the first mismatch
module executeStageTb;
    import isaPkg::*;
    import pipePkg::*;

    typedef struct packed {
        instrE instr;
        regAddrT addrRs;
        regAddrT addrRt;
        imm16T imm16;
        shamtT shamt;
        regAddrT memAddr;
        regAddrT wbAddr;
        logic zeroRt;
        logic stall;
        logic clr;
    } rowT;

    logic clk;
    logic reset;
    logic stall;
    logic clr;
    exInputT exIn;
    bypassT bypassMem;
    bypassT bypassWb;
    memInputT memOut;
    logic mdBusy;

    rowT tests[$];
    logic tableReady;
    logic [31:0] lfsr;

    // Reference model state
    memInputT expMem;
    logic expBusy;
    wordT modelHi;
    wordT modelLo;
    int mdCount;
    string lastName;

    executeStage DUT (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .clr      (clr),
        .exIn     (exIn),
        .bypassMem(bypassMem),
        .bypassWb (bypassWb),
        .memOut   (memOut),
        .mdBusy   (mdBusy)
    );

    always #10 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] randomBits(int count);
        logic [31:0] value;
        logic fb;
        value = '0;
        for (int i = 0; i < count; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    task automatic abortRun();
        $display("Test failed");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic compareValue(string name, logic [255:0] expected, logic [255:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
            abortRun();
        end
    endtask

    task automatic addRow(instrE op, imm16T imm = '0, shamtT sa = '0, regAddrT rs = 5'd1,
                          regAddrT rt = 5'd2, regAddrT memA = '0, regAddrT wbA = '0,
                          logic stallIn = 1'b0, logic clrIn = 1'b0, logic zeroRt = 1'b0);
        rowT row;
        row = '{op, rs, rt, imm, sa, memA, wbA, zeroRt, stallIn, clrIn};
        tests.push_back(row);
    endtask

    task automatic addIdle(int count);
        repeat (count) addRow(NOP);
    endtask

    task automatic buildTable();
        // Register forms
        addRow(ADD);
        addRow(ADDU);
        addRow(SUB);
        addRow(SUBU);
        addRow(AND);
        addRow(OR);
        addRow(XOR);
        addRow(NOR);
        addRow(SLT);
        addRow(SLTU);
        addRow(SLL, 16'h0, 5'd7);
        addRow(SRL, 16'h0, 5'd13);
        addRow(SRA, 16'h0, 5'd31);
        addRow(SLLV);
        addRow(SRLV);
        addRow(SRAV);
        // Immediate forms, both immediate signs
        addRow(ADDI, 16'h8001);
        addRow(ADDIU, 16'h7ff0);
        addRow(ANDI, 16'hf0f0);
        addRow(ORI, 16'h8888);
        addRow(XORI, 16'hffff);
        addRow(LUI, 16'h8765);
        addRow(SLTI, 16'h8000);
        addRow(SLTIU, 16'hffff);
        addRow(LW, 16'hfffc);
        addRow(SW, 16'h0010);
        // Forwarding priority and register 0
        addRow(ADD, 16'h0, 5'd0, 5'd3, 5'd4, 5'd3, 5'd4);
        addRow(SUB, 16'h0, 5'd0, 5'd5, 5'd5, 5'd5, 5'd5);
        addRow(OR, 16'h0, 5'd0, 5'd0, 5'd0);
        addRow(SW, 16'h0004, 5'd0, 5'd7, 5'd6, 5'd9, 5'd6);
        // Multiply and divide, reads while busy give 0
        addRow(MULT);
        addRow(MFHI);
        addIdle(4);
        addRow(MFHI);
        addRow(MFLO);
        addRow(MULTU);
        addRow(DIV);
        addIdle(4);
        addRow(MFHI);
        addRow(MFLO);
        addRow(DIV);
        addRow(MFLO);
        addIdle(9);
        addRow(MFHI);
        addRow(MFLO);
        addRow(DIVU, 16'h0, 5'd0, 5'd1, 5'd2, 5'd0, 5'd0, 1'b0, 1'b0, 1'b1);
        addIdle(10);
        addRow(MFHI);
        addRow(MFLO);
        addRow(MTHI);
        addRow(MTLO);
        addRow(MFHI);
        addRow(MFLO);
        // Stall holds, clear beats stall
        addRow(ADD);
        addRow(XOR, 16'h0, 5'd0, 5'd1, 5'd2, 5'd0, 5'd0, 1'b1);
        addRow(MULT, 16'h0, 5'd0, 5'd1, 5'd2, 5'd0, 5'd0, 1'b1);
        addRow(NOR);
        addRow(ADD, 16'h0, 5'd0, 5'd1, 5'd2, 5'd0, 5'd0, 1'b0, 1'b1);
        addRow(SUB, 16'h0, 5'd0, 5'd1, 5'd2, 5'd0, 5'd0, 1'b1, 1'b1);
        addRow(LW, 16'h0020);
    endtask

    function automatic wordT forwardModel(regAddrT addr, wordT fileData);
        if (addr == '0) begin
            return fileData;
        end
        if (bypassMem.addr == addr) begin
            return bypassMem.data;
        end
        if (bypassWb.addr == addr) begin
            return bypassWb.data;
        end
        return fileData;
    endfunction

    function automatic wordT aluModel(instrE op, wordT rs, wordT rt, imm16T imm, shamtT sa);
        wordT sImm;
        wordT zImm;
        sImm = {{16{imm[15]}}, imm};
        zImm = {16'h0, imm};
        case (op)
            ADD, ADDU: return rs + rt;
            SUB, SUBU: return rs - rt;
            AND: return rs & rt;
            OR: return rs | rt;
            XOR: return rs ^ rt;
            NOR: return ~(rs | rt);
            SLT: return wordT'($signed(rs) < $signed(rt));
            SLTU: return wordT'(rs < rt);
            SLL: return rt << sa;
            SRL: return rt >> sa;
            SRA: return $signed(rt) >>> sa;
            SLLV: return rt << rs[4:0];
            SRLV: return rt >> rs[4:0];
            SRAV: return $signed(rt) >>> rs[4:0];
            ADDI, ADDIU, LW, SW: return rs + sImm;
            ANDI: return rs & zImm;
            ORI: return rs | zImm;
            XORI: return rs ^ zImm;
            LUI: return {imm, 16'h0};
            SLTI: return wordT'($signed(rs) < $signed(sImm));
            SLTIU: return wordT'(rs < sImm);
            default: return '0;
        endcase
    endfunction

    // Instructions whose write-back data is the execute result
    function automatic logic writesResult(instrE op);
        return !(op inside {NOP, LW, SW, MULT, MULTU, DIV, DIVU});
    endfunction

    task automatic updateMultDiv(instrE op, logic stallIn, wordT rsV, wordT rtV);
        logic [63:0] product;
        logic idle;
        idle = !stallIn && mdCount == 0;
        if (idle && op inside {MULT, MULTU}) begin
            if (op == MULT) begin
                product = longint'($signed(rsV)) * longint'($signed(rtV));
            end else begin
                product = {32'h0, rsV} * {32'h0, rtV};
            end
            modelHi = product[63:32];
            modelLo = product[31:0];
            mdCount = MULT_CYCLES;
        end else if (idle && op inside {DIV, DIVU}) begin
            if (rtV == '0) begin
                modelHi = rsV;
                modelLo = '1;
            end else if (op == DIV) begin
                modelHi = wordT'(longint'($signed(rsV)) % longint'($signed(rtV)));
                modelLo = wordT'(longint'($signed(rsV)) / longint'($signed(rtV)));
            end else begin
                modelHi = rsV % rtV;
                modelLo = rsV / rtV;
            end
            mdCount = DIV_CYCLES;
        end else if (idle && op == MTHI) begin
            modelHi = rsV;
        end else if (idle && op == MTLO) begin
            modelLo = rsV;
        end else if (mdCount != 0) begin
            mdCount = mdCount - 1;
        end
    endtask

    task automatic applyRow(int idx);
        rowT row;
        wordT rsV;
        wordT rtV;
        wordT result;
        memInputT next;
        row = tests[idx];
        exIn.instr = row.instr;
        exIn.pc = randomBits(32);
        exIn.dataRs = randomBits(32);
        exIn.dataRt = row.zeroRt ? '0 : randomBits(32);
        exIn.imm16 = row.imm16;
        exIn.shamt = row.shamt;
        exIn.addrRs = row.addrRs;
        exIn.addrRt = row.addrRt;
        exIn.regWriteAddr = regAddrT'(randomBits(5));
        exIn.regWriteData = randomBits(32);
        exIn.tNew = tNewT'(randomBits(2));
        bypassMem.addr = row.memAddr;
        bypassMem.data = randomBits(32);
        bypassWb.addr = row.wbAddr;
        bypassWb.data = randomBits(32);
        stall = row.stall;
        clr = row.clr;
        lastName = $sformatf("row %0d %s", idx, row.instr.name());

        rsV = forwardModel(row.addrRs, exIn.dataRs);
        rtV = forwardModel(row.addrRt, exIn.dataRt);
        if (row.instr == MFHI) begin
            result = (mdCount != 0) ? '0 : modelHi;
        end else if (row.instr == MFLO) begin
            result = (mdCount != 0) ? '0 : modelLo;
        end else begin
            result = aluModel(row.instr, rsV, rtV, row.imm16, row.shamt);
        end
        next.instr = row.instr;
        next.pc = exIn.pc;
        next.aluOut = result;
        next.memWriteData = rtV;
        next.addrRt = row.addrRt;
        next.regWriteAddr = exIn.regWriteAddr;
        next.regWriteData = writesResult(row.instr) ? result : exIn.regWriteData;
        next.tNew = (exIn.tNew == '0) ? '0 : exIn.tNew - 2'd1;
        if (row.clr) begin
            expMem = '0;
        end else if (!row.stall) begin
            expMem = next;
        end
        updateMultDiv(row.instr, row.stall, rsV, rtV);
        expBusy = (mdCount != 0);
    endtask

    task automatic checkOutputs();
        compareValue({lastName, " memOut"}, 256'(expMem), 256'(memOut));
        compareValue({lastName, " mdBusy"}, 256'(expBusy), 256'(mdBusy));
    endtask

    initial begin
        tableReady = 1'b0;
        wait (tableReady);
        repeat (tests.size() * (DIV_CYCLES + 4)) @(posedge clk);
        $display("Watchdog expired before all table rows were applied");
        abortRun();
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        stall = 1'b0;
        clr = 1'b0;
        exIn = '0;
        bypassMem = '0;
        bypassWb = '0;
        lfsr = 32'h2b3b;
        expMem = '0;
        expBusy = 1'b0;
        modelHi = '0;
        modelLo = '0;
        mdCount = 0;
        lastName = "reset";
        buildTable();
        tableReady = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < tests.size(); i++) begin
            @(negedge clk);
            checkOutputs();
            applyRow(i);
        end
        @(negedge clk);
        checkOutputs();
        $display("Test passed");
        $finish;
    end

endmodule

// File: tb.f
source/isaPkg.sv
source/pipePkg.sv
source/instrClassifier.sv
source/operandForward.sv
source/aluUnit.sv
source/multDivUnit.sv
source/exMemRegister.sv
source/executeStage.sv
test/executeStageTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= executeStageTb
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
